// ==== Makefile ====
# Verilator simulation of the CFT control unit

VERILATOR ?= verilator
TOP       ?= tb_control_unit
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== cft_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Shared widths, unit codes and the microinstruction layout
// Only opcodes with their own microprogram are named; others run as a nop
// Strobes in the control word are active low, as on the CFT memory bus
////////////////////////////////////////////////////////////////////////////

package cft_pkg;

   // Data and address width, one word per location
   localparam int word_w   = 16;
   // Micro-step counter, up to 16 steps per microprogram
   localparam int step_w   = 4;
   // Address split used by the AGL
   localparam int page_w   = 6;
   localparam int offset_w = 10;

   // Instruction opcodes, IR bits 15:12
   typedef enum logic [3:0] {
      op_trap = 4'd0,
      op_load = 4'd2,
      op_stor = 4'd3,
      op_jmp  = 4'd6,
      op_op1  = 4'd12,
      op_op2  = 4'd13
   } opcode_t;

   // Unit that drives the internal bus
   typedef enum logic [2:0] {
      ru_none = 3'd0,
      ru_pc   = 3'd1,
      ru_agl  = 3'd2,
      ru_a    = 3'd3,
      ru_mem  = 3'd4
   } read_unit_t;

   // Unit that latches the internal bus at the end of the cycle
   typedef enum logic [2:0] {
      wu_none = 3'd0,
      wu_mar  = 3'd1,
      wu_pc   = 3'd2,
      wu_ir   = 3'd3,
      wu_a    = 3'd4,
      wu_mem  = 3'd5
   } write_unit_t;

   // One microinstruction, 14 bits
   typedef struct packed {
      read_unit_t  read_unit;
      write_unit_t write_unit;
      logic        inc_pc;
      logic        inc_a;
      logic        eval_skip;  // latch skip condition this cycle
      logic        mem_n;
      logic        rd_n;
      logic        wr_n;
      logic        halt;
      logic        end_n;      // low restarts the fetch
   } ctrl_word_t;

   // Nothing moves, no strobe, sequence continues
   localparam ctrl_word_t ctrl_idle = '{
      read_unit:  ru_none,
      write_unit: wu_none,
      inc_pc:     1'b0,
      inc_a:      1'b0,
      eval_skip:  1'b0,
      mem_n:      1'b1,
      rd_n:       1'b1,
      wr_n:       1'b1,
      halt:       1'b0,
      end_n:      1'b1
   };

endpackage

// ==== control_unit.sv ====
////////////////////////////////////////////////////////////////////////////
// CFT control unit top, sequencer and datapath on the memory bus
// reset_pc sets the first fetch address; halt stays high until reset
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module control_unit
   import cft_pkg::*;
#(
   parameter logic [word_w-1:0] reset_pc = '0
) (
   input  logic              clock,
   input  logic              rst_n,
   output logic [word_w-1:0] addr,
   output logic [word_w-1:0] wdata,
   input  logic [word_w-1:0] rdata,
   output logic              mem_n,
   output logic              rd_n,
   output logic              wr_n,
   output logic              halt
);

   ctrl_word_t        ctrl;
   logic [word_w-1:0] ir;
   logic [word_w-1:0] acc;
   logic              skip_cond;

   // Opcode in the top nibble of the IR
   micro_sequencer u_seq (
      .clock     (clock),
      .rst_n     (rst_n),
      .opcode    (opcode_t'(ir[word_w-1 -: 4])),
      .skip_cond (skip_cond),
      .ctrl      (ctrl),
      .halt      (halt)
   );

   skip_unit u_skip (
      .acc       (acc),
      .skip_mask (ir[1:0]),
      .skip_cond (skip_cond)
   );

   register_datapath #(
      .reset_pc (reset_pc)
   ) u_dp (
      .clock (clock),
      .rst_n (rst_n),
      .ctrl  (ctrl),
      .rdata (rdata),
      .addr  (addr),
      .wdata (wdata),
      .mem_n (mem_n),
      .rd_n  (rd_n),
      .wr_n  (wr_n),
      .ir    (ir),
      .acc   (acc)
   );

endmodule

// ==== filelist.f ====
cft_pkg.sv
microcode_rom.sv
micro_sequencer.sv
skip_unit.sv
register_datapath.sv
control_unit.sv
tb_control_unit.sv

// ==== micro_sequencer.sv ====
////////////////////////////////////////////////////////////////////////////
// Micro-step counter and registered skip flag around the microcode ROM
// Step returns to 0 after end_n and holds while halt is high
// Skip keeps its value between OP1 instructions
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module micro_sequencer
   import cft_pkg::*;
(
   input  logic       clock,
   input  logic       rst_n,
   input  opcode_t    opcode,
   input  logic       skip_cond,
   output ctrl_word_t ctrl,
   output logic       halt
);

   logic [step_w-1:0] step;
   logic              skip;

   microcode_rom u_rom (
      .opcode (opcode),
      .skip   (skip),
      .step   (step),
      .ctrl   (ctrl)
   );

   // Step counter
   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         step <= '0;
      end else if (!ctrl.end_n) begin
         step <= '0;
      end else if (!ctrl.halt) begin
         step <= step + 1'b1;
      end
   end

   // Skip flag loads only when the microprogram asks
   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         skip <= 1'b0;
      end else if (ctrl.eval_skip) begin
         skip <= skip_cond;
      end
   end

   assign halt = ctrl.halt;

   // One strobe at a time, and never outside a memory cycle
   a_strobes: assert property (@(posedge clock) disable iff (!rst_n)
      (!ctrl.rd_n || !ctrl.wr_n) |-> (!ctrl.mem_n && (ctrl.rd_n != ctrl.wr_n)));

endmodule

// ==== microcode_rom.sv ====
////////////////////////////////////////////////////////////////////////////
// Microcode table addressed by opcode, registered skip flag and step
// Purely combinational; steps past the end of a program return to fetch
// Fetch takes steps 0 and 1 for every opcode
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module microcode_rom
   import cft_pkg::*;
(
   input  opcode_t           opcode,
   input  logic              skip,
   input  logic [step_w-1:0] step,
   output ctrl_word_t        ctrl
);

   always_comb begin
      // Idle unless a step below says otherwise
      ctrl = ctrl_idle;
      case (step)
         // Fetch, PC to MAR
         step_w'(0): begin
            ctrl.read_unit  = ru_pc;
            ctrl.write_unit = wu_mar;
         end
         // Fetch, memory to IR and step PC past the instruction
         step_w'(1): begin
            ctrl.read_unit  = ru_mem;
            ctrl.write_unit = wu_ir;
            ctrl.mem_n      = 1'b0;
            ctrl.rd_n       = 1'b0;
            ctrl.inc_pc     = 1'b1;
         end
         // First execute step, IR now holds the opcode
         step_w'(2): begin
            case (opcode)
               op_load, op_stor: begin
                  ctrl.read_unit  = ru_agl;
                  ctrl.write_unit = wu_mar;
               end
               op_jmp: begin
                  ctrl.read_unit  = ru_agl;
                  ctrl.write_unit = wu_pc;
                  ctrl.end_n      = 1'b0;
               end
               op_op1: begin
                  ctrl.eval_skip = 1'b1;
               end
               op_op2: begin
                  ctrl.inc_a = 1'b1;
                  ctrl.end_n = 1'b0;
               end
               // TRAP parks here until reset
               op_trap: begin
                  ctrl.halt = 1'b1;
               end
               default: begin
                  ctrl.end_n = 1'b0;
               end
            endcase
         end
         // Second execute step
         step_w'(3): begin
            ctrl.end_n = 1'b0;
            case (opcode)
               op_load: begin
                  ctrl.read_unit  = ru_mem;
                  ctrl.write_unit = wu_a;
                  ctrl.mem_n      = 1'b0;
                  ctrl.rd_n       = 1'b0;
               end
               op_stor: begin
                  ctrl.read_unit  = ru_a;
                  ctrl.write_unit = wu_mem;
                  ctrl.mem_n      = 1'b0;
                  ctrl.wr_n       = 1'b0;
               end
               // Skip the next instruction
               op_op1: begin
                  ctrl.inc_pc = skip;
               end
               default: begin
                  ctrl.inc_pc = 1'b0;
               end
            endcase
         end
         // Unused step, back to fetch
         default: begin
            ctrl.end_n = 1'b0;
         end
      endcase
   end

endmodule

// ==== register_datapath.sv ====
////////////////////////////////////////////////////////////////////////////
// Register file, internal bus and memory port of the control unit
// One value moves per cycle; memory must answer in the same cycle
// The AGL takes its page from PC after the fetch increment
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module register_datapath
   import cft_pkg::*;
#(
   parameter logic [word_w-1:0] reset_pc = '0
) (
   input  logic              clock,
   input  logic              rst_n,
   input  ctrl_word_t        ctrl,
   input  logic [word_w-1:0] rdata,
   output logic [word_w-1:0] addr,
   output logic [word_w-1:0] wdata,
   output logic              mem_n,
   output logic              rd_n,
   output logic              wr_n,
   output logic [word_w-1:0] ir,
   output logic [word_w-1:0] acc
);

   logic [word_w-1:0] pc;
   logic [word_w-1:0] mar;
   logic [word_w-1:0] agl;
   logic [word_w-1:0] ibus;
   logic              r_flag;
   logic              w_mar;
   logic              w_pc;
   logic              w_ir;
   logic              w_a;
   logic              w_mem;

   //////////////////////////////////////////////////////////////////////////
   // Unit decode and internal bus
   //////////////////////////////////////////////////////////////////////////

   assign w_mar = (ctrl.write_unit == wu_mar);
   assign w_pc  = (ctrl.write_unit == wu_pc);
   assign w_ir  = (ctrl.write_unit == wu_ir);
   assign w_a   = (ctrl.write_unit == wu_a);
   assign w_mem = (ctrl.write_unit == wu_mem);

   // Bus reads as zero when nothing drives it
   always_comb begin
      case (ctrl.read_unit)
         ru_pc:   ibus = pc;
         ru_agl:  ibus = agl;
         ru_a:    ibus = acc;
         ru_mem:  ibus = rdata;
         default: ibus = '0;
      endcase
   end

   //////////////////////////////////////////////////////////////////////////
   // Address generation
   //////////////////////////////////////////////////////////////////////////

   // R flag clear selects page zero
   assign r_flag = ir[offset_w];
   assign agl    = {pc[word_w-1 -: page_w] & {page_w{r_flag}}, ir[offset_w-1:0]};

   //////////////////////////////////////////////////////////////////////////
   // Registers
   //////////////////////////////////////////////////////////////////////////

   // PC where a bus write wins over the increment
   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         pc <= reset_pc;
      end else if (w_pc) begin
         pc <= ibus;
      end else if (ctrl.inc_pc) begin
         pc <= pc + 1'b1;
      end
   end

   always_ff @(posedge clock) begin
      if (w_mar) begin
         mar <= ibus;
      end
      if (w_ir) begin
         ir <= ibus;
      end
      // A wraps at 16 bits on increment
      if (w_a) begin
         acc <= ibus;
      end else if (ctrl.inc_a) begin
         acc <= acc + 1'b1;
      end
   end

   // Memory port
   assign addr  = mar;
   assign wdata = w_mem ? ibus : '0;
   assign mem_n = ctrl.mem_n;
   assign rd_n  = ctrl.rd_n;
   assign wr_n  = ctrl.wr_n;

   // A bus write to memory and the write strobe go together
   a_mem_write: assert property (@(posedge clock) disable iff (!rst_n)
      w_mem == !wr_n);

endmodule

// ==== skip_unit.sv ====
////////////////////////////////////////////////////////////////////////////
// Flag unit and skip condition for the OP1 group
// Mask bit 0 tests Z, bit 1 tests N; both set skip on either
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module skip_unit
   import cft_pkg::*;
(
   input  logic [word_w-1:0] acc,
   input  logic [1:0]        skip_mask,
   output logic              skip_cond
);

   logic flag_n;
   logic flag_z;

   // Two's complement sign
   assign flag_n = acc[word_w-1];

   // Zero test over the whole accumulator
   assign flag_z = (acc == '0);

   // Masked conditions ORed together
   assign skip_cond = (skip_mask[0] & flag_z) | (skip_mask[1] & flag_n);

endmodule

// ==== tb_control_unit.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for the CFT control unit with a zero-wait 64k-word memory
// Each table row runs one fixed program from reset_pc until TRAP halts
// Memory is refilled with an address-based pattern for every row
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_control_unit
   import cft_pkg::*;
();

   localparam logic [word_w-1:0] reset_pc        = 16'h0C00;
   localparam int                num_rows        = 8;
   localparam int                clk_period      = 4;
   localparam int                watchdog_cycles = num_rows * 200;
   // Edge cases first, then LFSR words
   localparam logic [word_w-1:0] fixed_data [3]  = '{16'h0000, 16'h8000, 16'hFFFF};
   // JMP target and the R=1 store both sit in the page of the program
   localparam logic [word_w-1:0] jump_target = {reset_pc[word_w-1 -: page_w], 10'h030};
   localparam logic [word_w-1:0] page_slot   = {reset_pc[word_w-1 -: page_w], 10'h020};

   logic              clock;
   logic              rst_n;
   logic [word_w-1:0] addr;
   logic [word_w-1:0] wdata;
   logic [word_w-1:0] rdata;
   logic              mem_n;
   logic              rd_n;
   logic              wr_n;
   logic              halt;

   logic [word_w-1:0] mem [0:65535];
   logic [word_w-1:0] row_data [num_rows];
   logic              row_page [num_rows];
   logic [1:0]        row_mask [num_rows];
   logic [word_w-1:0] row_inc  [num_rows];
   logic              row_skip [num_rows];
   logic [15:0]       lfsr_state;
   // Bus monitor state
   logic              prev_strobe;
   logic              first_pending;
   logic              halted;

   control_unit #(
      .reset_pc (reset_pc)
   ) DUT (
      .clock (clock),
      .rst_n (rst_n),
      .addr  (addr),
      .wdata (wdata),
      .rdata (rdata),
      .mem_n (mem_n),
      .rd_n  (rd_n),
      .wr_n  (wr_n),
      .halt  (halt)
   );

   initial clock = 1'b0;
   always #(clk_period / 2) clock = ~clock;

   ////////////////////////////////////////////////////////////////////////////
   // Memory model
   ////////////////////////////////////////////////////////////////////////////

   // Answers in the same cycle as the read strobe
   assign rdata = (!mem_n && !rd_n) ? mem[addr] : '0;

   always @(posedge clock) begin
      if (!mem_n && !wr_n) begin
         mem[addr] = wdata;
      end
   end

   task automatic report_mismatch(input string name, input logic [15:0] got,
                                  input logic [15:0] exp);
      $display("FAILED %s got %h expected %h", name, got, exp);
      $display("SOME TESTS FAILED");
      $fatal(1, "value mismatch");
   endtask

   task automatic report_error(input string msg);
      $display("%s", msg);
      $display("SOME TESTS FAILED");
      $fatal(1, "bus check");
   endtask

   // Background word that every address bit feeds into
   function automatic logic [15:0] fill_word(input logic [15:0] a);
      return {a[7:0], a[15:8]} ^ a ^ 16'hA5C3;
   endfunction

   // Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   task automatic take_bits(input int n, output logic [15:0] val);
      val = '0;
      for (int i = 0; i < n; i++) begin
         val        = {val[14:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
   endtask

   // Opcode, bit 11 unused, R flag, in-page offset
   function automatic logic [15:0] encode_instr(input logic [3:0] op, input logic r,
                                                input logic [9:0] off);
      return {op, 1'b0, r, off};
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus table
   ////////////////////////////////////////////////////////////////////////////

   task automatic build_table();
      logic [15:0] v;
      lfsr_state = 16'd94;
      for (int i = 0; i < num_rows; i++) begin
         if (i < 3) begin
            row_data[i] = fixed_data[i];
            row_page[i] = i[0];
            row_mask[i] = 2'(i + 1);
         end else begin
            take_bits(16, v);
            row_data[i] = v;
            take_bits(1, v);
            row_page[i] = v[0];
            take_bits(2, v);
            row_mask[i] = v[1:0];
         end
         // OP2 wraps at 16 bits
         row_inc[i]  = row_data[i] + 16'd1;
         // Z on bit 0, N on bit 1
         row_skip[i] = (row_mask[i][0] && row_data[i] == '0) ||
                       (row_mask[i][1] && row_data[i][15]);
      end
   endtask

   task automatic load_memory(input int row);
      logic [15:0] prog [10];
      for (int a = 0; a < 65536; a++) begin
         mem[a] = fill_word(16'(a));
      end
      mem[16'h0010] = row_data[row];
      prog[0] = encode_instr(4'h2, 1'b0, 10'h010);
      prog[1] = encode_instr(4'h3, row_page[row], 10'h020);
      // Opcode without a microprogram runs as a nop
      prog[2] = 16'h9000;
      prog[3] = encode_instr(4'hD, 1'b0, 10'h000);
      prog[4] = encode_instr(4'h3, 1'b0, 10'h021);
      prog[5] = encode_instr(4'h2, 1'b0, 10'h010);
      prog[6] = encode_instr(4'hC, 1'b0, {8'h00, row_mask[row]});
      // Marker store that runs only when OP1 does not skip
      prog[7] = encode_instr(4'h3, 1'b0, 10'h022);
      prog[8] = encode_instr(4'h6, 1'b1, 10'h030);
      prog[9] = encode_instr(4'h3, 1'b0, 10'h023);
      for (int k = 0; k < 10; k++) begin
         mem[reset_pc + 16'(k)] = prog[k];
      end
      mem[jump_target]         = encode_instr(4'h3, 1'b0, 10'h024);
      mem[jump_target + 16'd1] = 16'h0000;
   endtask

   task automatic check_word(input logic [15:0] a, input logic [15:0] exp);
      assert (mem[a] == exp)
      else report_mismatch($sformatf("mem[%h]", a), mem[a], exp);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Bus monitor on the values from before each rising edge
   ////////////////////////////////////////////////////////////////////////////

   always @(posedge clock) begin
      if (!rst_n) begin
         prev_strobe   = 1'b0;
         first_pending = 1'b1;
         halted        = 1'b0;
      end else begin
         assert (rd_n || wr_n) else report_error("read and write strobes low together");
         assert ((rd_n && wr_n) || !mem_n) else report_error("strobe low without mem_n");
         assert (!(prev_strobe && !mem_n)) else report_error("memory cycle longer than one clock");
         if (halted) begin
            assert (mem_n && rd_n && wr_n) else report_error("memory strobe after halt");
         end
         // First fetch comes from the start address
         if (!rd_n && first_pending) begin
            assert (addr == reset_pc) else report_mismatch("addr", addr, reset_pc);
            first_pending = 1'b0;
         end
         prev_strobe = !mem_n;
         halted      = halted || halt;
      end
   end

   task automatic run_row(input int row);
      @(negedge clock);
      rst_n = 1'b0;
      load_memory(row);
      repeat (3) begin
         @(negedge clock);
         assert (mem_n && rd_n && wr_n && !halt)
         else report_error("strobes or halt active during reset");
      end
      rst_n = 1'b1;
      while (!halt) @(negedge clock);
      // A few idle cycles so the monitor sees the parked state
      repeat (4) @(negedge clock);
      assert (halt) else report_error("halt dropped before reset");
      check_word(16'h0010, row_data[row]);
      if (row_page[row]) begin
         check_word(16'h0020, fill_word(16'h0020));
         check_word(page_slot, row_data[row]);
      end else begin
         check_word(16'h0020, row_data[row]);
         check_word(page_slot, fill_word(page_slot));
      end
      check_word(16'h0021, row_inc[row]);
      check_word(16'h0022, row_skip[row] ? fill_word(16'h0022) : row_data[row]);
      // STOR behind the JMP never runs
      check_word(16'h0023, fill_word(16'h0023));
      check_word(16'h0024, row_data[row]);
   endtask

   initial begin
      rst_n = 1'b0;
      build_table();
      for (int r = 0; r < num_rows; r++) begin
         run_row(r);
      end
      $display("ALL TESTS PASSED");
      $finish;
   end

   // Watchdog
   initial begin
      #(watchdog_cycles * clk_period);
      $display("Timeout after %0d cycles, programs did not all reach halt", watchdog_cycles);
      $display("SOME TESTS FAILED");
      $fatal(1, "watchdog expired");
   end

endmodule
